/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = pipe_trace_tb
FILELIST  = pipe_trace.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/pipe_trace_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_trace_chk (
    input wire        clk,
    input wire        rst,
    input wire        awvalid,
    input wire        awready,
    input wire        wvalid,
    input wire        wready,
    input wire        bvalid,
    input wire        bready,
    input wire [1:0]  bresp,
    input wire        arvalid,
    input wire        arready,
    input wire        rvalid,
    input wire        rready,
    input wire [1:0]  rresp,
    input wire [31:0] rdata
);

    int unsigned fail_count = 0;                   // Assertion failures so far

    ////////////////////////////////////////
    // Response hold under back-pressure
    ////////////////////////////////////////
    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_count++;
        end

    rdata_stable: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> $stable(rdata))
        else begin
            $error("rdata changed while rvalid waited");
            fail_count++;
        end

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    // Always OKAY
    rresp_okay: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rresp == 2'b00)
        else begin
            $error("read response other than OKAY");
            fail_count++;
        end

    bresp_okay: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> bresp == 2'b00)
        else begin
            $error("write response other than OKAY");
            fail_count++;
        end

    ////////////////////////////////////////
    // No response without a request
    ////////////////////////////////////////
    read_caused: assert property (@(posedge clk) disable iff (rst)
        $rose(rvalid) |-> $past(arvalid && arready))
        else begin
            $error("rvalid without an AR handshake");
            fail_count++;
        end

    write_caused: assert property (@(posedge clk) disable iff (rst)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
        else begin
            $error("bvalid without an AW and W handshake");
            fail_count++;
        end

endmodule

`default_nettype wire

/* bench/pipe_trace_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_trace_tb import trace_pkg::*; ();

    localparam int TIMEOUT = 64;                   // Cycles per wait

    logic        clk = 1'b0;
    logic        rst;
    logic        fetch_valid;
    logic [31:0] decode_instr;
    logic        stall;
    logic        flush;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // Reference model of the shadow pipeline
    logic [STAGES-1:0]  m_valid;
    logic               m_flushed [STAGES];
    logic [STAMP_W-1:0] m_fstamp  [STAGES];
    logic [STALL_W-1:0] m_stalls  [STAGES];
    logic [31:0]        m_word    [STAGES];
    logic [STAMP_W-1:0] m_stamp;
    logic               m_fresh;                   // Slot 1 loaded on the last edge
    logic [DROP_W-1:0]  m_drops;
    logic [REC_W-1:0]   exp_q [$];
    int                 seq = 0;
    int                 checks = 0;
    int                 errors = 0;
    logic [31:0]        lfsr = 32'hf88a_6bbf;

    pipe_trace_top UUT (.*);

    bind trace_axil pipe_trace_chk u_chk (
        .clk(clk), .rst(rst), .awvalid(awvalid), .awready(awready),
        .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
        .bresp(bresp), .arvalid(arvalid), .arready(arready), .rvalid(rvalid),
        .rready(rready), .rresp(rresp), .rdata(rdata)
    );

    always #20 clk = ~clk;

    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    task automatic move_slot(input int dst, input int src, input logic mark);
        m_valid[dst]   = m_valid[src];
        m_flushed[dst] = m_flushed[src] | mark;
        m_fstamp[dst]  = m_fstamp[src];
        m_stalls[dst]  = m_stalls[src];
        m_word[dst]    = m_word[src];
    endtask

    ////////////////////////////////////////
    // Model update, one step per clock
    ////////////////////////////////////////
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_valid = '0;
            m_stamp = '0;
            m_fresh = 1'b0;
            m_drops = '0;
        end else begin
            if (m_valid[4]) begin                  // Retires on this edge
                if (exp_q.size() < FIFO_DEPTH) begin
                    exp_q.push_back({m_flushed[4], 3'b000, m_stalls[4], m_stamp,
                                     m_fstamp[4], m_word[4]});
                end else if (m_drops != '1) begin
                    m_drops = m_drops + 16'd1;
                end
            end
            move_slot(4, 3, 1'b0);
            move_slot(3, 2, 1'b0);
            if (flush || !stall) begin
                move_slot(2, 1, flush);
                move_slot(1, 0, flush);
                m_valid[0]   = flush | fetch_valid;
                m_flushed[0] = 1'b0;
                m_fstamp[0]  = m_stamp + 12'd1;
                m_stalls[0]  = '0;
                m_word[0]    = {16'hc0de, seq[15:0]};
                if (m_valid[0]) seq++;
            end else begin
                m_valid[2] = 1'b0;                 // Bubble
                if (m_stalls[1] != 4'hf) m_stalls[1] = m_stalls[1] + 4'd1;
            end
            m_fresh = flush | ~stall;
            m_stamp = m_stamp + 12'd1;
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic pipe_cycle(input logic fv, input logic st, input logic fl);
        @(negedge clk);
        fetch_valid = fv;
        stall       = st;
        flush       = fl;
        if (m_fresh && m_valid[1]) begin
            decode_instr = m_word[1];
        end else begin
            decode_instr = {16'hbad0, 4'h0, m_stamp};  // Capture must not take this
        end
    endtask

    task automatic drain_pipe();
        int wait_cnt;
        wait_cnt = 0;
        while (|m_valid) begin
            pipe_cycle(1'b0, 1'b0, 1'b0);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) abort_on_timeout("the pipeline to drain");
        end
    endtask

    ////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////
    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        int wait_cnt;
        int hold;
        @(negedge clk);
        araddr   = addr;
        arvalid  = 1'b1;
        wait_cnt = 0;
        while (!arready) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) abort_on_timeout("arready");
        end
        @(negedge clk);                            // AR taken on the edge just passed
        arvalid  = 1'b0;
        wait_cnt = 0;
        while (!rvalid) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) abort_on_timeout("rvalid");
        end
        hold = int'({lfsr_bit(), lfsr_bit()});
        repeat (hold) @(negedge clk);              // Back-pressure on rready
        data   = rdata;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        int wait_cnt;
        int hold;
        @(negedge clk);
        awaddr   = addr;
        awvalid  = 1'b1;
        wdata    = data;
        wstrb    = 4'hf;
        wvalid   = 1'b1;
        wait_cnt = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) abort_on_timeout("awready and wready");
        end
        @(negedge clk);
        awvalid  = 1'b0;
        wvalid   = 1'b0;
        wait_cnt = 0;
        while (!bvalid) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) abort_on_timeout("bvalid");
        end
        hold = int'({lfsr_bit(), lfsr_bit()});
        repeat (hold) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic check_status();
        logic [31:0] w;
        axi_read(REG_STATUS, w);
        compare_word("status", w, {m_drops, 16'(exp_q.size())});
    endtask

    // Header is read twice before the popping read of the instruction
    task automatic check_head(input logic plain);
        logic [31:0]      hdr_a;
        logic [31:0]      hdr_b;
        logic [31:0]      instr;
        logic [REC_W-1:0] want;
        want = exp_q.pop_front();
        axi_read(REG_HDR, hdr_a);
        axi_read(REG_HDR, hdr_b);
        axi_read(REG_INSTR, instr);
        compare_word("record header", hdr_a, want[63:32]);
        compare_word("repeated header", hdr_b, want[63:32]);
        compare_word("record instruction", instr, want[31:0]);
        if (plain) begin
            compare_word("unstalled retire stamp", {20'h0, hdr_a[23:12]},
                         {20'h0, want[43:32] + 12'd4});
            compare_word("unstalled flags", {24'h0, hdr_a[31:24]}, 32'h0);
        end
    endtask

    initial begin
        logic        fv;
        logic        st;
        logic        fl;
        logic [31:0] w;
        rst = 1'b1;
        fetch_valid = 1'b0;
        decode_instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Back-to-back fetches without stalls
        for (int i = 0; i < 6; i++) pipe_cycle(1'b1, 1'b0, 1'b0);
        drain_pipe();
        check_status();
        while (exp_q.size() > 0) check_head(1'b1);

        // Random stalls and flushes
        for (int i = 0; i < 30; i++) begin
            fv = lfsr_bit();
            st = lfsr_bit() & lfsr_bit();
            fl = lfsr_bit() & lfsr_bit() & lfsr_bit();
            pipe_cycle(fv, st, fl);
        end
        drain_pipe();
        check_status();
        while (exp_q.size() > 0) check_head(1'b0);

        // Long stall saturates the counter before the flushes
        repeat (2) pipe_cycle(1'b1, 1'b0, 1'b0);
        repeat (20) pipe_cycle(1'b1, 1'b1, 1'b0);
        repeat (3) pipe_cycle(1'b1, 1'b0, 1'b0);
        pipe_cycle(1'b1, 1'b0, 1'b1);
        pipe_cycle(1'b0, 1'b1, 1'b1);              // Flush beats stall
        drain_pipe();
        check_status();
        while (exp_q.size() > 0) check_head(1'b0);

        // Overflow without reads and a clear of the drop counter
        repeat (20) pipe_cycle(1'b1, 1'b0, 1'b0);
        drain_pipe();
        check_status();
        axi_write(REG_CTRL, 32'h0);                // Bit 0 low is ignored
        check_status();
        axi_write(REG_CTRL, 32'h1);
        m_drops = '0;
        check_status();
        while (exp_q.size() > 0) check_head(1'b1);
        axi_read(REG_INSTR, w);
        compare_word("read of an empty FIFO", w, 32'h0);
        check_status();

        $display("Checks %0d, errors %0d, bound assertion failures %0d",
                 checks, errors, UUT.u_axil.u_chk.fail_count);
        if (errors == 0 && UUT.u_axil.u_chk.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pipe_trace.f */
verilog/trace_pkg.sv
verilog/trace_fifo.sv
verilog/trace_capture.sv
verilog/trace_axil.sv
verilog/pipe_trace_top.sv
bench/pipe_trace_chk.sv
bench/pipe_trace_tb.sv

/* verilog/pipe_trace_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_trace_top import trace_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    // Pipeline controls
    input  wire         fetch_valid,
    input  wire  [31:0] decode_instr,
    input  wire         stall,
    input  wire         flush,
    // AXI4-Lite slave
    input  wire  [3:0]  awaddr,
    input  wire         awvalid,
    output logic        awready,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wstrb,
    input  wire         wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  wire         bready,
    input  wire  [3:0]  araddr,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  wire         rready
);

    logic              push;
    logic [REC_W-1:0]  push_data;
    logic              pop;
    logic [REC_W-1:0]  rd_data;
    logic [FIFO_AW:0]  count;
    logic              full;
    logic              empty;
    logic              drop_clear;
    logic [DROP_W-1:0] drop_count;

    trace_capture u_capture (
        .clk, .rst, .fetch_valid, .stall, .flush, .full, .drop_clear,
        .decode_instr, .push, .push_data, .drop_count
    );

    trace_fifo u_fifo (
        .clk, .rst, .push, .pop, .push_data, .rd_data, .count, .full, .empty
    );

    trace_axil u_axil (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .rd_data, .count, .empty, .drop_count, .pop, .drop_clear
    );

endmodule

`default_nettype wire

/* verilog/trace_axil.sv */
`timescale 1ns/100ps
`default_nettype none

module trace_axil import trace_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    // Write address and data
    input  wire  [3:0]        awaddr,
    input  wire               awvalid,
    output logic              awready,
    input  wire  [31:0]       wdata,
    input  wire  [3:0]        wstrb,
    input  wire               wvalid,
    output logic              wready,
    // Write response
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  wire               bready,
    // Read address and data
    input  wire  [3:0]        araddr,
    input  wire               arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  wire               rready,
    // Record FIFO and capture side
    input  wire  [REC_W-1:0]  rd_data,
    input  wire  [FIFO_AW:0]  count,
    input  wire               empty,
    input  wire  [DROP_W-1:0] drop_count,
    output logic              pop,
    output logic              drop_clear
);

    logic        wr_fire;
    logic        rd_fire;
    logic [31:0] rd_word;
    trace_hdr_u  head_hdr;

    // AW and W are taken as a pair
    assign wr_fire  = awvalid & awready & wvalid & wready;
    assign rd_fire  = arvalid & arready;
    assign head_hdr = rd_data[REC_W-1:REC_W-32];

    assign bresp = 2'b00;                          // OKAY
    assign rresp = 2'b00;

    // Pop lands on the same edge that registers the response
    assign pop = rd_fire & (araddr == REG_INSTR) & ~empty;

    always_comb begin
        case (araddr)
            REG_STATUS: rd_word = {drop_count, (32-DROP_W)'(count)};
            REG_HDR:    rd_word = head_hdr.raw;
            REG_INSTR:  rd_word = empty ? 32'h0 : rd_data[31:0];
            default:    rd_word = 32'h0;
        endcase
    end

    ////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready    <= 1'b1;
            wready     <= 1'b1;
            bvalid     <= 1'b0;
            drop_clear <= 1'b0;
        end else begin
            drop_clear <= 1'b0;
            if (wr_fire) begin
                awready    <= 1'b0;                // One write in flight
                wready     <= 1'b0;
                bvalid     <= 1'b1;
                drop_clear <= (awaddr == REG_CTRL) & wstrb[0] & wdata[0];
            end else if (bvalid && bready) begin
                bvalid  <= 1'b0;
                awready <= 1'b1;
                wready  <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else begin
            if (rd_fire) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid  <= 1'b0;
                arready <= 1'b1;
            end
        end
    end

    // Held until rready
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* verilog/trace_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module trace_capture import trace_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               fetch_valid,
    input  wire               stall,
    input  wire               flush,
    input  wire               full,
    input  wire               drop_clear,
    input  wire  [31:0]       decode_instr,
    output logic              push,
    output logic [REC_W-1:0]  push_data,
    output logic [DROP_W-1:0] drop_count
);

    logic [STAMP_W-1:0] stamp;                     // Free-running cycle stamp
    logic [STAGES-1:0]  slot_valid;
    logic [STAGES-1:0]  slot_flushed;
    logic [STAMP_W-1:0] slot_fstamp [STAGES];
    logic [STALL_W-1:0] slot_stalls [STAGES];
    logic [31:0]        slot_instr  [1:STAGES-1];  // Known from decode onward
    logic               s1_new;                    // Slot 1 was loaded on the last edge
    logic               advance;
    logic               take;
    logic [31:0]        s1_instr;
    trace_hdr_u         hdr;

    // Flush wins over stall
    assign advance  = flush | ~stall;
    assign take     = flush | (fetch_valid & ~stall);

    // Decode word is live only in the first cycle an entry sits in slot 1
    assign s1_instr = s1_new ? decode_instr : slot_instr[1];

    ////////////////////////////////////////
    // Valid bits, stamp, drop counter
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stamp      <= '0;
            slot_valid <= '0;
            s1_new     <= 1'b0;
            drop_count <= '0;
        end else begin
            stamp  <= stamp + 1'b1;
            s1_new <= advance;

            if (advance) begin
                slot_valid[2:0] <= {slot_valid[1:0], take};
            end else begin
                slot_valid[2] <= 1'b0;             // Bubble behind the held slots
            end
            slot_valid[STAGES-1:3] <= slot_valid[STAGES-2:2];

            // Clear beats a drop in the same cycle
            if (drop_clear) begin
                drop_count <= '0;
            end else if (slot_valid[STAGES-1] && full && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Shadow payload
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (advance) begin
            slot_fstamp[0]  <= stamp + 1'b1;       // First cycle spent in slot 0
            slot_stalls[0]  <= '0;
            slot_flushed[0] <= 1'b0;               // New fetch always enters clean
            slot_fstamp[1]  <= slot_fstamp[0];
            slot_stalls[1]  <= slot_stalls[0];
            slot_flushed[1] <= slot_flushed[0] | flush;
        end else begin
            slot_instr[1] <= s1_instr;             // Keep decoded word while held
            if (slot_stalls[1] != '1) begin
                slot_stalls[1] <= slot_stalls[1] + 1'b1;
            end
        end

        // Slot 2 payload is ignored while a bubble sits there
        slot_instr[2]   <= s1_instr;
        slot_fstamp[2]  <= slot_fstamp[1];
        slot_stalls[2]  <= slot_stalls[1];
        slot_flushed[2] <= slot_flushed[1] | flush;

        for (int i = 3; i < STAGES; i++) begin
            slot_instr[i]   <= slot_instr[i-1];
            slot_fstamp[i]  <= slot_fstamp[i-1];
            slot_stalls[i]  <= slot_stalls[i-1];
            slot_flushed[i] <= slot_flushed[i-1];
        end
    end

    ////////////////////////////////////////
    // Retire
    ////////////////////////////////////////
    always_comb begin
        hdr.f.flushed      = slot_flushed[STAGES-1];
        hdr.f.rsvd         = '0;
        hdr.f.stall_count  = slot_stalls[STAGES-1];
        hdr.f.retire_stamp = stamp;                // Cycle spent in write-back
        hdr.f.fetch_stamp  = slot_fstamp[STAGES-1];
    end

    // Slot 4 never holds, so this is a one-cycle strobe per entry
    assign push      = slot_valid[STAGES-1] & ~full;
    assign push_data = {hdr, slot_instr[STAGES-1]};

endmodule

`default_nettype wire

/* verilog/trace_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module trace_fifo import trace_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               push,
    input  wire               pop,
    input  wire  [REC_W-1:0]  push_data,
    output logic [REC_W-1:0]  rd_data,
    output logic [FIFO_AW:0]  count,
    output logic              full,
    output logic              empty
);

    logic [REC_W-1:0]   mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               do_push;
    logic               do_pop;

    // Safety net only, producers already gate these
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];                  // Head shown before the pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;           // Depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/trace_pkg.sv */
`default_nettype none

package trace_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int STAGES     = 5;             // IF, ID, EX, MEM, WB
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;
    localparam int STAMP_W    = 12;            // Wraps around
    localparam int STALL_W    = 4;             // Saturates at 15
    localparam int DROP_W     = 16;            // Saturates
    localparam int REC_W      = 64;            // Header word, then instruction word

    ////////////////////////////////////////
    // AXI4-Lite register map
    ////////////////////////////////////////
    localparam logic [3:0] REG_STATUS = 4'h0;  // Drop count | record count
    localparam logic [3:0] REG_HDR    = 4'h4;  // Head header, no pop
    localparam logic [3:0] REG_INSTR  = 4'h8;  // Head instruction, pops
    localparam logic [3:0] REG_CTRL   = 4'hC;  // Bit 0 clears the drop count

    ////////////////////////////////////////
    // Record header
    ////////////////////////////////////////
    typedef struct packed {
        logic               flushed;
        logic [2:0]         rsvd;
        logic [STALL_W-1:0] stall_count;
        logic [STAMP_W-1:0] retire_stamp;
        logic [STAMP_W-1:0] fetch_stamp;
    } trace_hdr_fields_t;

    // Built from fields in capture, read back raw on the bus
    typedef union packed {
        logic [31:0]       raw;
        trace_hdr_fields_t f;
    } trace_hdr_u;

endpackage

`default_nettype wire
